// ==== common/qs_pkg.sv ====
`include "qs_settings.svh"

package qs_pkg;

  localparam int ADDR_W = $clog2(`QS_N);
  localparam int BANK_ID_W = (`QS_BANKS_N > 1) ? $clog2(`QS_BANKS_N) : 1;

  typedef logic [`QS_W-1:0] w_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BANK_ID_W-1:0] bank_id_t;
  // One extra bit so a full bank can be counted
  typedef logic [ADDR_W:0] bank_cnt_t;

  // Life cycle of a bank
  typedef enum logic [2:0] {
    BANK_IDLE,
    BANK_ENQ,
    BANK_READY,
    BANK_SORTING,
    BANK_SORTED,
    BANK_DEQ
  } bank_status_t;

  // Round-robin step over the banks
  function automatic bank_id_t next_bank(bank_id_t id);
    if (id == bank_id_t'(`QS_BANKS_N - 1)) begin
      return '0;
    end
    return id + 1'b1;
  endfunction

endpackage

// ==== common/qs_settings.svh ====
`ifndef QS_SETTINGS_SVH
`define QS_SETTINGS_SVH

// Width of a stored word
`define QS_W 32

// Entries per bank, also the longest frame
`define QS_N 16

// Number of banks in the store
`define QS_BANKS_N 2

`endif

// ==== qs_top.f ====
+incdir+common
common/qs_pkg.sv
rtl/banks/spsram.sv
rtl/banks/qs_banks.sv
rtl/qs_enq.sv
rtl/qs_sort.sv
rtl/qs_deq.sv
rtl/qs_top.sv
test/qs_top_asserts.sv
test/qs_top_tb.sv

// ==== rtl/banks/qs_banks.sv ====
`timescale 1ns/1ns
`include "qs_settings.svh"

module qs_banks (
  input  logic                 clk,
  input  logic                 rst,
  // Enqueue client
  input  qs_pkg::bank_id_t     enq_idx,
  input  logic                 enq_in_vld,
  input  qs_pkg::bank_status_t enq_in_status,
  input  qs_pkg::bank_cnt_t    enq_in_cnt,
  output qs_pkg::bank_status_t enq_out_status,
  output qs_pkg::bank_cnt_t    enq_out_cnt,
  input  logic                 enq_wr_en,
  input  qs_pkg::addr_t        enq_wr_addr,
  input  qs_pkg::w_t           enq_wr_data,
  // Sort client
  input  qs_pkg::bank_id_t     srt_idx,
  input  logic                 srt_in_vld,
  input  qs_pkg::bank_status_t srt_in_status,
  input  qs_pkg::bank_cnt_t    srt_in_cnt,
  output qs_pkg::bank_status_t srt_out_status,
  output qs_pkg::bank_cnt_t    srt_out_cnt,
  input  logic                 srt_en,
  input  logic                 srt_wen,
  input  qs_pkg::addr_t        srt_addr,
  input  qs_pkg::w_t           srt_wdata,
  output logic                 srt_rdata_vld,
  output qs_pkg::w_t           srt_rdata,
  // Dequeue client
  input  qs_pkg::bank_id_t     deq_idx,
  input  logic                 deq_in_vld,
  input  qs_pkg::bank_status_t deq_in_status,
  input  qs_pkg::bank_cnt_t    deq_in_cnt,
  output qs_pkg::bank_status_t deq_out_status,
  output qs_pkg::bank_cnt_t    deq_out_cnt,
  input  logic                 deq_rd_en,
  input  qs_pkg::addr_t        deq_rd_addr,
  output logic                 deq_rd_data_vld,
  output qs_pkg::w_t           deq_rd_data
);

  import qs_pkg::*;

  localparam int NB = `QS_BANKS_N;

  // Per-bank status and word count
  bank_status_t status_q [NB];
  bank_cnt_t    cnt_q [NB];

  // One-hot status update requests
  logic [NB-1:0] st_enq_sel;
  logic [NB-1:0] st_srt_sel;
  logic [NB-1:0] st_deq_sel;

  // One-hot memory requests
  logic [NB-1:0] mem_enq_sel;
  logic [NB-1:0] mem_srt_sel;
  logic [NB-1:0] mem_deq_sel;

  // RAM side of each bank
  logic [NB-1:0] ram_en;
  logic [NB-1:0] ram_wen;
  addr_t         ram_addr [NB];
  w_t            ram_din [NB];
  w_t            ram_dout [NB];

  // Read return paths, index 0 is sort and 1 is dequeue
  logic [1:0] rd_win;
  bank_id_t   rd_idx [2];
  logic [1:0] rd_q;
  bank_id_t   rd_bank_q [2];
  logic [1:0] rd_vld_q;
  w_t         rd_data_q [2];

  always_comb begin
    for (int b = 0; b < NB; b++) begin
      st_enq_sel[b] = enq_in_vld && (enq_idx == bank_id_t'(b));
      st_srt_sel[b] = srt_in_vld && (srt_idx == bank_id_t'(b));
      st_deq_sel[b] = deq_in_vld && (deq_idx == bank_id_t'(b));
      mem_enq_sel[b] = enq_wr_en && (enq_idx == bank_id_t'(b));
      mem_srt_sel[b] = srt_en && (srt_idx == bank_id_t'(b));
      mem_deq_sel[b] = deq_rd_en && (deq_idx == bank_id_t'(b));
    end
  end

  // Status updates, enqueue first then sort then dequeue
  always_ff @(posedge clk) begin
    for (int b = 0; b < NB; b++) begin
      if (rst) begin
        status_q[b] <= BANK_IDLE;
        cnt_q[b]    <= '0;
      end else if (st_enq_sel[b]) begin
        status_q[b] <= enq_in_status;
        cnt_q[b]    <= enq_in_cnt;
      end else if (st_srt_sel[b]) begin
        status_q[b] <= srt_in_status;
        cnt_q[b]    <= srt_in_cnt;
      end else if (st_deq_sel[b]) begin
        status_q[b] <= deq_in_status;
        cnt_q[b]    <= deq_in_cnt;
      end
    end
  end

  // Each client watches the bank under its own pointer
  assign enq_out_status = status_q[enq_idx];
  assign enq_out_cnt    = cnt_q[enq_idx];
  assign srt_out_status = status_q[srt_idx];
  assign srt_out_cnt    = cnt_q[srt_idx];
  assign deq_out_status = status_q[deq_idx];
  assign deq_out_cnt    = cnt_q[deq_idx];

  // Memory port mux, same priority order as status
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      ram_en[b]   = 1'b1;
      ram_wen[b]  = 1'b0;
      ram_addr[b] = '0;
      ram_din[b]  = '0;
      if (mem_enq_sel[b]) begin
        ram_wen[b]  = 1'b1;
        ram_addr[b] = enq_wr_addr;
        ram_din[b]  = enq_wr_data;
      end else if (mem_srt_sel[b]) begin
        ram_wen[b]  = srt_wen;
        ram_addr[b] = srt_addr;
        ram_din[b]  = srt_wdata;
      end else if (mem_deq_sel[b]) begin
        ram_addr[b] = deq_rd_addr;
      end else begin
        ram_en[b] = 1'b0;
      end
    end
  end

  // A read only counts if it won its bank
  assign rd_win[0] = srt_en && !srt_wen && !mem_enq_sel[srt_idx];
  assign rd_win[1] = deq_rd_en && !mem_enq_sel[deq_idx] && !mem_srt_sel[deq_idx];
  assign rd_idx[0] = srt_idx;
  assign rd_idx[1] = deq_idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q     <= '0;
      rd_vld_q <= '0;
    end else begin
      rd_q     <= rd_win;
      rd_vld_q <= rd_q;
    end
  end

  // Remember the source bank, then register its RAM output
  always_ff @(posedge clk) begin
    for (int c = 0; c < 2; c++) begin
      if (rd_win[c]) begin
        rd_bank_q[c] <= rd_idx[c];
      end
      if (rd_q[c]) begin
        rd_data_q[c] <= ram_dout[rd_bank_q[c]];
      end
    end
  end

  assign srt_rdata_vld   = rd_vld_q[0];
  assign srt_rdata       = rd_data_q[0];
  assign deq_rd_data_vld = rd_vld_q[1];
  assign deq_rd_data     = rd_data_q[1];

  for (genvar g = 0; g < NB; g++) begin : g_bank
    spsram #(
      .W (`QS_W),
      .N (`QS_N)
    ) u_ram (
      .clk  (clk),
      .en   (ram_en[g]),
      .wen  (ram_wen[g]),
      .addr (ram_addr[g]),
      .din  (ram_din[g]),
      .dout (ram_dout[g])
    );
  end

endmodule

// ==== rtl/banks/spsram.sv ====
`timescale 1ns/1ns

module spsram #(
  parameter int W = 32,
  parameter int N = 16
) (
  input  logic                 clk,
  input  logic                 en,
  input  logic                 wen,
  input  logic [$clog2(N)-1:0] addr,
  input  logic [W-1:0]         din,
  output logic [W-1:0]         dout
);

  logic [W-1:0] mem [N];

  // One port, read data appears the cycle after the request
  always_ff @(posedge clk) begin
    if (en) begin
      if (wen) begin
        mem[addr] <= din;
      end else begin
        dout <= mem[addr];
      end
    end
  end

endmodule

// ==== rtl/qs_deq.sv ====
`timescale 1ns/1ns

module qs_deq (
  input  logic                 clk,
  input  logic                 rst,
  output qs_pkg::bank_id_t     bank_idx,
  output logic                 bank_in_vld,
  output qs_pkg::bank_status_t bank_in_status,
  output qs_pkg::bank_cnt_t    bank_in_cnt,
  input  qs_pkg::bank_status_t bank_out_status,
  input  qs_pkg::bank_cnt_t    bank_out_cnt,
  output logic                 rd_en,
  output qs_pkg::addr_t        rd_addr,
  input  logic                 rd_data_vld,
  input  qs_pkg::w_t           rd_data,
  output logic                 out_vld,
  output qs_pkg::w_t           out_data,
  output logic                 out_last
);

  import qs_pkg::*;

  typedef enum logic [1:0] {
    S_WAIT,
    S_READ,
    S_DONE
  } state_t;

  state_t     state;
  bank_cnt_t  ptr;
  logic       final_rd;
  // Tag travels beside the read, two stages to match the data
  logic       rd_last;
  logic [1:0] last_pipe;

  assign final_rd = ((ptr + 1'b1) == bank_out_cnt);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_WAIT;
      bank_idx    <= '0;
      bank_in_vld <= 1'b0;
      rd_en       <= 1'b0;
      rd_last     <= 1'b0;
      last_pipe   <= '0;
    end else begin
      bank_in_vld <= 1'b0;
      rd_en       <= 1'b0;
      rd_last     <= 1'b0;
      last_pipe   <= {last_pipe[0], rd_last};
      case (state)
        S_WAIT: begin
          if (bank_out_status == BANK_SORTED) begin
            bank_in_vld    <= 1'b1;
            bank_in_status <= BANK_DEQ;
            bank_in_cnt    <= bank_out_cnt;
            ptr            <= '0;
            state          <= S_READ;
          end
        end
        S_READ: begin
          // One read per cycle in address order
          rd_en   <= 1'b1;
          rd_addr <= addr_t'(ptr);
          ptr     <= ptr + 1'b1;
          if (final_rd) begin
            rd_last        <= 1'b1;
            bank_in_vld    <= 1'b1;
            bank_in_status <= BANK_IDLE;
            bank_in_cnt    <= '0;
            state          <= S_DONE;
          end
        end
        S_DONE: begin
          bank_idx <= next_bank(bank_idx);
          state    <= S_WAIT;
        end
        default: state <= S_WAIT;
      endcase
    end
  end

  // Returned words go straight out
  assign out_vld  = rd_data_vld;
  assign out_data = rd_data;
  // Tag pipe lines up with the last returned word
  assign out_last = last_pipe[1];

endmodule

// ==== rtl/qs_enq.sv ====
`timescale 1ns/1ns
`include "qs_settings.svh"

module qs_enq (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_vld,
  input  qs_pkg::w_t           in_data,
  input  logic                 in_last,
  output logic                 in_busy,
  output qs_pkg::bank_id_t     bank_idx,
  output logic                 bank_in_vld,
  output qs_pkg::bank_status_t bank_in_status,
  output qs_pkg::bank_cnt_t    bank_in_cnt,
  input  qs_pkg::bank_status_t bank_out_status,
  output logic                 wr_en,
  output qs_pkg::addr_t        wr_addr,
  output qs_pkg::w_t           wr_data
);

  import qs_pkg::*;

  typedef enum logic [1:0] {
    S_WAIT,
    S_FILL,
    S_DONE
  } state_t;

  state_t    state;
  bank_cnt_t cnt;
  logic      accept;
  logic      close;

  // Only take words once a bank is ours
  assign in_busy = (state != S_FILL);
  assign accept  = in_vld && !in_busy;

  // Frame ends on the flag or when the bank fills up
  assign close = in_last || (cnt == bank_cnt_t'(`QS_N - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_WAIT;
      bank_idx    <= '0;
      bank_in_vld <= 1'b0;
      wr_en       <= 1'b0;
      cnt         <= '0;
    end else begin
      bank_in_vld <= 1'b0;
      wr_en       <= 1'b0;
      case (state)
        S_WAIT: begin
          // Claim the bank as soon as it is free
          if (bank_out_status == BANK_IDLE) begin
            bank_in_vld    <= 1'b1;
            bank_in_status <= BANK_ENQ;
            bank_in_cnt    <= '0;
            cnt            <= '0;
            state          <= S_FILL;
          end
        end
        S_FILL: begin
          if (accept) begin
            wr_en   <= 1'b1;
            wr_addr <= addr_t'(cnt);
            wr_data <= in_data;
            cnt     <= cnt + 1'b1;
            if (close) begin
              // Hand the filled bank to the sorter
              bank_in_vld    <= 1'b1;
              bank_in_status <= BANK_READY;
              bank_in_cnt    <= cnt + 1'b1;
              state          <= S_DONE;
            end
          end
        end
        S_DONE: begin
          // Last write and READY update go out this cycle
          bank_idx <= next_bank(bank_idx);
          state    <= S_WAIT;
        end
        default: state <= S_WAIT;
      endcase
    end
  end

endmodule

// ==== rtl/qs_sort.sv ====
`timescale 1ns/1ns

module qs_sort (
  input  logic                 clk,
  input  logic                 rst,
  output qs_pkg::bank_id_t     bank_idx,
  output logic                 bank_in_vld,
  output qs_pkg::bank_status_t bank_in_status,
  output qs_pkg::bank_cnt_t    bank_in_cnt,
  input  qs_pkg::bank_status_t bank_out_status,
  input  qs_pkg::bank_cnt_t    bank_out_cnt,
  output logic                 en,
  output logic                 wen,
  output qs_pkg::addr_t        addr,
  output qs_pkg::w_t           wdata,
  input  logic                 rdata_vld,
  input  qs_pkg::w_t           rdata
);

  import qs_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD2,
    S_GETA,
    S_GETB,
    S_SWAP,
    S_ADV,
    S_DONE
  } state_t;

  state_t state;
  // Lower index of the pair under compare
  addr_t  i;
  // Held copy of entry i
  w_t     a;
  logic   swapped;
  logic   pass_end;

  // Pair (i, i+1) is the last one of the pass
  assign pass_end = (({1'b0, i} + 2'd2) == bank_out_cnt);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      bank_idx    <= '0;
      bank_in_vld <= 1'b0;
      en          <= 1'b0;
      swapped     <= 1'b0;
    end else begin
      bank_in_vld <= 1'b0;
      en          <= 1'b0;
      case (state)
        S_IDLE: begin
          if (bank_out_status == BANK_READY) begin
            bank_in_vld <= 1'b1;
            bank_in_cnt <= bank_out_cnt;
            swapped     <= 1'b0;
            if (bank_out_cnt < bank_cnt_t'(2)) begin
              // Nothing to order
              bank_in_status <= BANK_SORTED;
              state          <= S_DONE;
            end else begin
              bank_in_status <= BANK_SORTING;
              i     <= '0;
              en    <= 1'b1;
              wen   <= 1'b0;
              addr  <= '0;
              state <= S_RD2;
            end
          end
        end
        S_RD2: begin
          // Second read right behind the first
          en    <= 1'b1;
          wen   <= 1'b0;
          addr  <= i + 1'b1;
          state <= S_GETA;
        end
        S_GETA: begin
          if (rdata_vld) begin
            a     <= rdata;
            state <= S_GETB;
          end
        end
        S_GETB: begin
          if (rdata_vld) begin
            if (a > rdata) begin
              // Out of order, smaller word goes to i first
              en      <= 1'b1;
              wen     <= 1'b1;
              addr    <= i;
              wdata   <= rdata;
              swapped <= 1'b1;
              state   <= S_SWAP;
            end else begin
              state <= S_ADV;
            end
          end
        end
        S_SWAP: begin
          en    <= 1'b1;
          wen   <= 1'b1;
          addr  <= i + 1'b1;
          wdata <= a;
          state <= S_ADV;
        end
        S_ADV: begin
          if (pass_end && !swapped) begin
            // Clean pass so the bank is in order
            bank_in_vld    <= 1'b1;
            bank_in_status <= BANK_SORTED;
            bank_in_cnt    <= bank_out_cnt;
            state          <= S_DONE;
          end else begin
            // Next pair, or restart at 0 for another pass
            en    <= 1'b1;
            wen   <= 1'b0;
            state <= S_RD2;
            if (pass_end) begin
              i       <= '0;
              addr    <= '0;
              swapped <= 1'b0;
            end else begin
              i    <= i + 1'b1;
              addr <= i + 1'b1;
            end
          end
        end
        S_DONE: begin
          bank_idx <= next_bank(bank_idx);
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/qs_top.sv ====
`timescale 1ns/1ns

module qs_top (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_vld,
  input  qs_pkg::w_t in_data,
  input  logic       in_last,
  output logic       in_busy,
  output logic       out_vld,
  output qs_pkg::w_t out_data,
  output logic       out_last
);

  import qs_pkg::*;

  // Enqueue side
  bank_id_t     enq_idx;
  logic         enq_in_vld;
  bank_status_t enq_in_status;
  bank_cnt_t    enq_in_cnt;
  bank_status_t enq_out_status;
  logic         enq_wr_en;
  addr_t        enq_wr_addr;
  w_t           enq_wr_data;

  // Sort side
  bank_id_t     srt_idx;
  logic         srt_in_vld;
  bank_status_t srt_in_status;
  bank_cnt_t    srt_in_cnt;
  bank_status_t srt_out_status;
  bank_cnt_t    srt_out_cnt;
  logic         srt_en;
  logic         srt_wen;
  addr_t        srt_addr;
  w_t           srt_wdata;
  logic         srt_rdata_vld;
  w_t           srt_rdata;

  // Dequeue side
  bank_id_t     deq_idx;
  logic         deq_in_vld;
  bank_status_t deq_in_status;
  bank_cnt_t    deq_in_cnt;
  bank_status_t deq_out_status;
  bank_cnt_t    deq_out_cnt;
  logic         deq_rd_en;
  addr_t        deq_rd_addr;
  logic         deq_rd_data_vld;
  w_t           deq_rd_data;

  qs_enq u_enq (
    .clk             (clk),
    .rst             (rst),
    .in_vld          (in_vld),
    .in_data         (in_data),
    .in_last         (in_last),
    .in_busy         (in_busy),
    .bank_idx        (enq_idx),
    .bank_in_vld     (enq_in_vld),
    .bank_in_status  (enq_in_status),
    .bank_in_cnt     (enq_in_cnt),
    .bank_out_status (enq_out_status),
    .wr_en           (enq_wr_en),
    .wr_addr         (enq_wr_addr),
    .wr_data         (enq_wr_data)
  );

  qs_sort u_sort (
    .clk             (clk),
    .rst             (rst),
    .bank_idx        (srt_idx),
    .bank_in_vld     (srt_in_vld),
    .bank_in_status  (srt_in_status),
    .bank_in_cnt     (srt_in_cnt),
    .bank_out_status (srt_out_status),
    .bank_out_cnt    (srt_out_cnt),
    .en              (srt_en),
    .wen             (srt_wen),
    .addr            (srt_addr),
    .wdata           (srt_wdata),
    .rdata_vld       (srt_rdata_vld),
    .rdata           (srt_rdata)
  );

  qs_deq u_deq (
    .clk             (clk),
    .rst             (rst),
    .bank_idx        (deq_idx),
    .bank_in_vld     (deq_in_vld),
    .bank_in_status  (deq_in_status),
    .bank_in_cnt     (deq_in_cnt),
    .bank_out_status (deq_out_status),
    .bank_out_cnt    (deq_out_cnt),
    .rd_en           (deq_rd_en),
    .rd_addr         (deq_rd_addr),
    .rd_data_vld     (deq_rd_data_vld),
    .rd_data         (deq_rd_data),
    .out_vld         (out_vld),
    .out_data        (out_data),
    .out_last        (out_last)
  );

  // Enqueue never needs its bank count back
  qs_banks u_banks (
    .clk             (clk),
    .rst             (rst),
    .enq_idx         (enq_idx),
    .enq_in_vld      (enq_in_vld),
    .enq_in_status   (enq_in_status),
    .enq_in_cnt      (enq_in_cnt),
    .enq_out_status  (enq_out_status),
    .enq_out_cnt     (),
    .enq_wr_en       (enq_wr_en),
    .enq_wr_addr     (enq_wr_addr),
    .enq_wr_data     (enq_wr_data),
    .srt_idx         (srt_idx),
    .srt_in_vld      (srt_in_vld),
    .srt_in_status   (srt_in_status),
    .srt_in_cnt      (srt_in_cnt),
    .srt_out_status  (srt_out_status),
    .srt_out_cnt     (srt_out_cnt),
    .srt_en          (srt_en),
    .srt_wen         (srt_wen),
    .srt_addr        (srt_addr),
    .srt_wdata       (srt_wdata),
    .srt_rdata_vld   (srt_rdata_vld),
    .srt_rdata       (srt_rdata),
    .deq_idx         (deq_idx),
    .deq_in_vld      (deq_in_vld),
    .deq_in_status   (deq_in_status),
    .deq_in_cnt      (deq_in_cnt),
    .deq_out_status  (deq_out_status),
    .deq_out_cnt     (deq_out_cnt),
    .deq_rd_en       (deq_rd_en),
    .deq_rd_addr     (deq_rd_addr),
    .deq_rd_data_vld (deq_rd_data_vld),
    .deq_rd_data     (deq_rd_data)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the qs_top testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  -f qs_top.f --top-module qs_top_tb -o qs_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/qs_top_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1

// ==== test/qs_top_asserts.sv ====
`timescale 1ns/1ns

module qs_top_asserts (
  input logic clk,
  input logic rst,
  input logic in_busy,
  input logic out_vld,
  input logic out_last
);

  // Output strobe must be driven once reset is over
  a_out_vld_known: assert property (
    @(posedge clk) disable iff (rst) !$isunknown(out_vld)
  ) else $error("out_vld is unknown after reset");

  // Frame end marker only rides on a valid word
  a_last_needs_vld: assert property (
    @(posedge clk) disable iff (rst) out_last |-> out_vld
  ) else $error("out_last high while out_vld is low");

  // No bank is claimed yet right after reset
  a_busy_after_rst: assert property (
    @(posedge clk) rst |=> in_busy
  ) else $error("in_busy low in the cycle after reset");

endmodule

bind qs_top qs_top_asserts u_asserts (
  .clk      (clk),
  .rst      (rst),
  .in_busy  (in_busy),
  .out_vld  (out_vld),
  .out_last (out_last)
);

// ==== test/qs_top_tb.sv ====
`timescale 1ns/1ns
`include "qs_settings.svh"

module qs_top_tb;

  import qs_pkg::*;

  typedef w_t frame_t [$];

  // Frames sent over the whole run, 1 + 2 + 2 + 6 + 2
  localparam int N_FRAMES = 13;
  // A reversed full bank needs about QS_N passes of QS_N pairs, ~6 cycles per pair
  localparam int CYC_PER_FRAME = 8 * `QS_N * `QS_N + 200;
  localparam int WATCHDOG_CYC = N_FRAMES * CYC_PER_FRAME + 50;

  logic clk = 1'b0;
  logic rst;
  logic in_vld;
  w_t   in_data;
  logic in_last;
  logic in_busy;
  logic out_vld;
  w_t   out_data;
  logic out_last;

  logic [31:0] rng_state = 32'h94e4e956;

  // Expected output stream, word plus its last flag
  w_t   exp_q [$];
  logic exp_last_q [$];
  w_t   exp_w;
  logic exp_l;

  int n_tests = 0;
  int n_checks = 0;
  int n_errors = 0;
  int err_mark = 0;

  always #2 clk = ~clk;

  qs_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .in_vld   (in_vld),
    .in_data  (in_data),
    .in_last  (in_last),
    .in_busy  (in_busy),
    .out_vld  (out_vld),
    .out_data (out_data),
    .out_last (out_last)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic w_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Insertion sort, ascending and unsigned
  function automatic frame_t sort_ref(frame_t f);
    frame_t s;
    w_t     key;
    int     j;
    s = f;
    for (int i = 1; i < s.size(); i++) begin
      key = s[i];
      j = i - 1;
      while (j >= 0 && s[j] > key) begin
        s[j+1] = s[j];
        j--;
      end
      s[j+1] = key;
    end
    return s;
  endfunction

  function automatic frame_t rand_frame(int len);
    frame_t f;
    for (int k = 0; k < len; k++) begin
      f.push_back(next_rand());
    end
    return f;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  // Queue the sorted frame for the compare process
  task automatic expect_frame(input frame_t f);
    frame_t s;
    s = sort_ref(f);
    for (int k = 0; k < s.size(); k++) begin
      exp_q.push_back(s[k]);
      exp_last_q.push_back(k == s.size() - 1);
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_word(input w_t w, input logic last);
    logic taken;
    in_vld  = 1'b1;
    in_data = w;
    in_last = last;
    taken   = 1'b0;
    while (!taken) begin
      // in_busy only moves on the edge, so it is stable here
      taken = !in_busy;
      @(posedge clk);
      #1;
    end
    in_vld  = 1'b0;
    in_last = 1'b0;
  endtask

  task automatic send_frame(input frame_t f, input logic mark_last);
    for (int k = 0; k < f.size(); k++) begin
      send_word(f[k], mark_last && (k == f.size() - 1));
    end
  endtask

  task automatic finish_test(input string name);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
    n_tests++;
    $display("test %0d %s: %s, %0d errors", n_tests, name,
             (n_errors == err_mark) ? "pass" : "fail", n_errors - err_mark);
    err_mark = n_errors;
  endtask

  // Compare on the falling edge, where outputs are settled
  always @(negedge clk) begin
    if (!rst && out_vld) begin
      if (exp_q.size() == 0) begin
        $display("unexpected output word %h at %0t ns with no frame pending",
                 out_data, $time);
        n_errors++;
      end else begin
        exp_w = exp_q.pop_front();
        exp_l = exp_last_q.pop_front();
        check_val("out_data", out_data, exp_w);
        check_val("out_last", {31'b0, out_last}, {31'b0, exp_l});
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("timeout: output did not drain within %0d cycles", WATCHDOG_CYC);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    frame_t f;
    frame_t head;
    frame_t tail;
    w_t     base;
    int     len;
    rst     = 1'b1;
    in_vld  = 1'b0;
    in_data = '0;
    in_last = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Full bank of random words
    f = rand_frame(`QS_N);
    expect_frame(f);
    send_frame(f, 1'b1);
    finish_test("full random frame");

    // Shortest frames, no pass or a single pair
    f = rand_frame(1);
    expect_frame(f);
    send_frame(f, 1'b1);
    f = rand_frame(2);
    expect_frame(f);
    send_frame(f, 1'b1);
    finish_test("frames of length 1 and 2");

    // Ties never swap, reversed order is the longest sort
    f.delete();
    base = next_rand();
    for (int k = 0; k < `QS_N; k++) begin
      f.push_back(base);
    end
    expect_frame(f);
    send_frame(f, 1'b1);
    f.delete();
    for (int k = 0; k < `QS_N; k++) begin
      f.push_back(32'h8000_0000 - 32'(k) * 32'h0001_0003);
    end
    expect_frame(f);
    send_frame(f, 1'b1);
    finish_test("equal and descending frames");

    // Both banks in use, order kept across them
    for (int n = 0; n < 6; n++) begin
      len = int'(next_rand() % `QS_N) + 1;
      f = rand_frame(len);
      expect_frame(f);
      send_frame(f, 1'b1);
    end
    finish_test("six back-to-back frames");

    // No last flag until word QS_N + 4
    f = rand_frame(`QS_N + 4);
    head.delete();
    tail.delete();
    for (int k = 0; k < f.size(); k++) begin
      if (k < `QS_N) begin
        head.push_back(f[k]);
      end else begin
        tail.push_back(f[k]);
      end
    end
    expect_frame(head);
    expect_frame(tail);
    send_frame(f, 1'b1);
    finish_test("frame closed at a full bank");

    repeat (20) @(posedge clk);
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0 && n_checks > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
